// File: src/mmio_cpl_pkg.sv
// MMIO completion path shared widths, field types and record layouts
`default_nettype none

package mmio_cpl_pkg;

   // --------------------------------------------------
   // Sizing
   // --------------------------------------------------
   localparam int NUM_BANKS       = 4;
   localparam int REGS_PER_BANK   = 8;
   localparam int NUM_IMPL_REGS   = 6;
   localparam int NUM_TAGS        = 16;
   localparam int MAX_OUTSTANDING = 2;
   // Bank strobe to response valid
   localparam int READ_LATENCY    = 2;

   // Address field positions
   localparam int ADDR_DW_BIT     = 2;
   localparam int ADDR_REG_LSB    = 3;
   localparam int ADDR_BANK_LSB   = 6;

   // --------------------------------------------------
   // Field types
   // --------------------------------------------------
   typedef logic [$clog2(NUM_TAGS)-1:0]          t_tag;
   typedef logic [15:0]                          t_req_id;
   typedef logic [11:0]                          t_addr;
   typedef logic [63:0]                          t_data;
   typedef logic [$clog2(NUM_BANKS)-1:0]         t_bank_idx;
   typedef logic [$clog2(REGS_PER_BANK)-1:0]     t_reg_idx;
   typedef logic [2:0]                           t_cpl_status;
   typedef logic [$clog2(MAX_OUTSTANDING+1)-1:0] t_out_cnt;

   localparam t_out_cnt    OUT_MAX = t_out_cnt'(MAX_OUTSTANDING);
   // Completion status codes
   localparam t_cpl_status CPL_SC  = 3'd0;
   localparam t_cpl_status CPL_UR  = 3'd1;

   // --------------------------------------------------
   // Records
   // --------------------------------------------------
   // Host request header with length in dwords
   typedef struct packed {
      t_tag       tag;
      t_req_id    req_id;
      t_addr      addr;
      logic [1:0] length;
      logic [2:0] attr;
      logic [2:0] tc;
   } t_mmio_req;

   // Bank read result
   typedef struct packed {
      t_tag  tag;
      t_data data;
      logic  err;
   } t_bank_rsp;

   // Outgoing completion record
   typedef struct packed {
      t_tag        tag;
      t_req_id     req_id;
      t_cpl_status status;
      logic [6:0]  lower_addr;
      logic [1:0]  length;
      logic [11:0] byte_count;
      logic [2:0]  attr;
      logic [2:0]  tc;
      t_data       data;
   } t_cpl;

endpackage : mmio_cpl_pkg

`default_nettype wire

// File: src/mmio_req_dispatch.sv
// Request dispatcher decoding banks, tracking read headers by tag and throttling reads
`timescale 1ns/10ps
`default_nettype none

module mmio_req_dispatch (
   input  wire                                   clk,
   input  wire                                   rst_n,
   input  wire                                   i_req_rd,
   input  wire                                   i_req_wr,
   input  mmio_cpl_pkg::t_mmio_req               i_req,
   input  mmio_cpl_pkg::t_data                   i_wr_data,
   input  mmio_cpl_pkg::t_tag                    i_lookup_tag,
   input  wire                                   i_cpl_done,
   output logic [mmio_cpl_pkg::NUM_BANKS-1:0]    o_bank_rd,
   output logic [mmio_cpl_pkg::NUM_BANKS-1:0]    o_bank_wr,
   output mmio_cpl_pkg::t_reg_idx                o_reg_idx,
   output mmio_cpl_pkg::t_tag                    o_tag,
   output mmio_cpl_pkg::t_data                   o_wr_data,
   output mmio_cpl_pkg::t_mmio_req               o_lookup_req,
   output logic                                  o_busy
);
   import mmio_cpl_pkg::*;

   t_bank_idx              req_bank;
   logic [NUM_BANKS-1:0]   bank_sel;
   t_out_cnt               out_cnt;
   t_mmio_req              tag_tbl [NUM_TAGS];

   // --------------------------------------------------
   // Address decode
   // --------------------------------------------------
   assign req_bank = i_req.addr[ADDR_BANK_LSB +: $bits(t_bank_idx)];

   // One-hot bank select
   always_comb begin
      bank_sel           = '0;
      bank_sel[req_bank] = 1'b1;
   end

   // Strobes one cycle after the request
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_bank_rd <= '0;
         o_bank_wr <= '0;
      end else begin
         o_bank_rd <= i_req_rd ? bank_sel : '0;
         o_bank_wr <= i_req_wr ? bank_sel : '0;
      end
   end

   // Offset, tag and data ride along with the strobe
   always_ff @(posedge clk) begin
      if (i_req_rd || i_req_wr) begin
         o_reg_idx <= i_req.addr[ADDR_REG_LSB +: $bits(t_reg_idx)];
         o_tag     <= i_req.tag;
         o_wr_data <= i_wr_data;
      end
   end

   // --------------------------------------------------
   // Tag tracker
   // --------------------------------------------------
   // Header kept per tag until the completion is built
   always_ff @(posedge clk) begin
      if (i_req_rd) begin
         tag_tbl[i_req.tag] <= i_req;
      end
   end

   // Same-cycle lookup for the builder
   assign o_lookup_req = tag_tbl[i_lookup_tag];

   // Reads in flight
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_cnt <= '0;
      end else if (i_req_rd && !i_cpl_done) begin
         out_cnt <= t_out_cnt'(out_cnt + 1'b1);
      end else if (!i_req_rd && i_cpl_done) begin
         out_cnt <= t_out_cnt'(out_cnt - 1'b1);
      end
   end

   // Stop the requester at the limit
   assign o_busy = (out_cnt == OUT_MAX);

endmodule : mmio_req_dispatch

`default_nettype wire

// File: src/csr_bank.sv
// CSR bank with six 64-bit registers, fixed-latency read and a two-entry response queue
`timescale 1ns/10ps
`default_nettype none

module csr_bank (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire                        i_rd,
   input  wire                        i_wr,
   input  mmio_cpl_pkg::t_reg_idx     i_reg_idx,
   input  mmio_cpl_pkg::t_tag         i_tag,
   input  mmio_cpl_pkg::t_data        i_wr_data,
   input  wire                        i_rsp_ready,
   output logic                       o_rsp_valid,
   output mmio_cpl_pkg::t_bank_rsp    o_rsp
);
   import mmio_cpl_pkg::*;

   localparam int PIPE_STAGES = READ_LATENCY - 1;

   t_data                   regs [NUM_IMPL_REGS];
   t_data                   rd_val;
   logic                    rd_err;
   t_bank_rsp               pipe_q   [PIPE_STAGES];
   logic [PIPE_STAGES-1:0]  pipe_vld;
   t_bank_rsp               q_mem    [2];
   logic                    q_wr_ptr;
   logic                    q_rd_ptr;
   logic [1:0]              q_cnt;
   logic                    q_push;
   logic                    q_pop;

   // --------------------------------------------------
   // Register file
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int r = 0; r < NUM_IMPL_REGS; r++) begin
            regs[r] <= '0;
         end
      end else if (i_wr) begin
         for (int r = 0; r < NUM_IMPL_REGS; r++) begin
            if (i_reg_idx == t_reg_idx'(r)) regs[r] <= i_wr_data;
         end
      end
   end

   // Read mux flagging indices past the implemented set
   always_comb begin
      rd_err = (i_reg_idx >= t_reg_idx'(NUM_IMPL_REGS));
      rd_val = '0;
      for (int r = 0; r < NUM_IMPL_REGS; r++) begin
         if (i_reg_idx == t_reg_idx'(r)) rd_val = regs[r];
      end
   end

   // --------------------------------------------------
   // Read latency pipe
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pipe_vld <= '0;
      end else begin
         pipe_vld[0] <= i_rd;
         for (int s = 1; s < PIPE_STAGES; s++) pipe_vld[s] <= pipe_vld[s-1];
      end
   end

   always_ff @(posedge clk) begin
      pipe_q[0] <= '{tag: i_tag, data: rd_val, err: rd_err};
      for (int s = 1; s < PIPE_STAGES; s++) pipe_q[s] <= pipe_q[s-1];
   end

   // --------------------------------------------------
   // Response queue
   // --------------------------------------------------
   // Last queue write completes the read latency
   assign q_push      = pipe_vld[PIPE_STAGES-1];
   assign q_pop       = o_rsp_valid && i_rsp_ready;
   assign o_rsp_valid = (q_cnt != 2'd0);
   assign o_rsp       = q_mem[q_rd_ptr];

   always_ff @(posedge clk) begin
      if (q_push) q_mem[q_wr_ptr] <= pipe_q[PIPE_STAGES-1];
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         q_wr_ptr <= 1'b0;
         q_rd_ptr <= 1'b0;
         q_cnt    <= 2'd0;
      end else begin
         if (q_push) q_wr_ptr <= ~q_wr_ptr;
         if (q_pop)  q_rd_ptr <= ~q_rd_ptr;
         q_cnt <= 2'(q_cnt + {1'b0, q_push} - {1'b0, q_pop});
      end
   end

endmodule : csr_bank

`default_nettype wire

// File: src/rsp_arbiter.sv
// Round-robin arbiter draining bank responses toward the completion builder
`timescale 1ns/10ps
`default_nettype none

module rsp_arbiter (
   input  wire                                              clk,
   input  wire                                              rst_n,
   input  wire  [mmio_cpl_pkg::NUM_BANKS-1:0]               i_rsp_valid,
   input  mmio_cpl_pkg::t_bank_rsp [mmio_cpl_pkg::NUM_BANKS-1:0] i_rsp,
   input  wire                                              i_ready,
   output logic [mmio_cpl_pkg::NUM_BANKS-1:0]               o_rsp_ready,
   output logic                                             o_rsp_valid,
   output mmio_cpl_pkg::t_bank_rsp                          o_rsp
);
   import mmio_cpl_pkg::*;

   t_bank_idx  ptr_q;
   t_bank_idx  sel_idx;
   logic       sel_found;

   // --------------------------------------------------
   // Pick first valid bank from the pointer on
   // --------------------------------------------------
   always_comb begin : pick
      t_bank_idx idx;
      sel_found = 1'b0;
      sel_idx   = ptr_q;
      for (int off = 0; off < NUM_BANKS; off++) begin
         idx = t_bank_idx'(ptr_q + off);
         if (!sel_found && i_rsp_valid[idx]) begin
            sel_found = 1'b1;
            sel_idx   = idx;
         end
      end
   end : pick

   assign o_rsp_valid = sel_found;
   assign o_rsp       = i_rsp[sel_idx];

   // Grant only when the builder can load
   always_comb begin
      o_rsp_ready = '0;
      if (sel_found && i_ready) o_rsp_ready[sel_idx] = 1'b1;
   end

   // Skip past the winner
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ptr_q <= '0;
      end else if (sel_found && i_ready) begin
         ptr_q <= t_bank_idx'(sel_idx + 1'b1);
      end
   end

endmodule : rsp_arbiter

`default_nettype wire

// File: src/cpl_builder.sv
// Completion builder merging a bank response with its tracked request header
`timescale 1ns/10ps
`default_nettype none

module cpl_builder (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire                        i_rsp_valid,
   input  mmio_cpl_pkg::t_bank_rsp    i_rsp,
   input  mmio_cpl_pkg::t_mmio_req    i_lookup_req,
   input  wire                        i_cpl_ready,
   output logic                       o_rsp_ready,
   output mmio_cpl_pkg::t_tag         o_lookup_tag,
   output mmio_cpl_pkg::t_cpl         o_cpl,
   output logic                       o_cpl_valid,
   output logic                       o_cpl_done
);
   import mmio_cpl_pkg::*;

   logic   load;
   t_cpl   cpl_d;
   t_data  cpl_data;
   logic   dw_shift;

   // --------------------------------------------------
   // Header lookup
   // --------------------------------------------------
   // Tracker answers in the same cycle
   assign o_lookup_tag = i_rsp.tag;

   // Single dword from the upper half
   assign dw_shift = (i_lookup_req.length == 2'd1) && i_lookup_req.addr[ADDR_DW_BIT];

   always_comb begin
      if (dw_shift) begin
         cpl_data = {32'h0, i_rsp.data[63:32]};
      end else begin
         cpl_data = i_rsp.data;
      end
   end

   // Record fields
   always_comb begin
      cpl_d            = '0;
      cpl_d.tag        = i_rsp.tag;
      cpl_d.req_id     = i_lookup_req.req_id;
      cpl_d.status     = i_rsp.err ? CPL_UR : CPL_SC;
      cpl_d.lower_addr = i_lookup_req.addr[6:0];
      cpl_d.length     = i_lookup_req.length;
      // Dwords to bytes
      cpl_d.byte_count = {8'h0, i_lookup_req.length, 2'b00};
      cpl_d.attr       = i_lookup_req.attr;
      cpl_d.tc         = i_lookup_req.tc;
      cpl_d.data       = cpl_data;
   end

   // --------------------------------------------------
   // Output register
   // --------------------------------------------------
   // Load when empty or draining this cycle
   assign load        = !o_cpl_valid || i_cpl_ready;
   assign o_rsp_ready = load;
   assign o_cpl_done  = o_cpl_valid && i_cpl_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_cpl_valid <= 1'b0;
      end else if (load) begin
         o_cpl_valid <= i_rsp_valid;
      end
   end

   // Record held while stalled
   always_ff @(posedge clk) begin
      if (load && i_rsp_valid) begin
         o_cpl <= cpl_d;
      end
   end

endmodule : cpl_builder

`default_nettype wire

// File: src/mmio_cpl_bridge.sv
// MMIO completion bridge top joining dispatcher, CSR banks, response arbiter and builder
`timescale 1ns/10ps
`default_nettype none

module mmio_cpl_bridge (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire                        i_req_rd,
   input  wire                        i_req_wr,
   input  mmio_cpl_pkg::t_mmio_req    i_req,
   input  mmio_cpl_pkg::t_data        i_wr_data,
   input  wire                        i_cpl_ready,
   output logic                       o_busy,
   output mmio_cpl_pkg::t_cpl         o_cpl,
   output logic                       o_cpl_valid
);
   import mmio_cpl_pkg::*;

   logic [NUM_BANKS-1:0]       bank_rd;
   logic [NUM_BANKS-1:0]       bank_wr;
   t_reg_idx                   reg_idx;
   t_tag                       tag;
   t_data                      wr_data;
   t_tag                       lookup_tag;
   t_mmio_req                  lookup_req;
   logic                       cpl_done;
   logic [NUM_BANKS-1:0]       bank_rsp_valid;
   t_bank_rsp [NUM_BANKS-1:0]  bank_rsp;
   logic [NUM_BANKS-1:0]       bank_rsp_ready;
   logic                       arb_valid;
   t_bank_rsp                  arb_rsp;
   logic                       arb_ready;

   mmio_req_dispatch dispatch_i (
      .clk (clk), .rst_n (rst_n),
      .i_req_rd (i_req_rd), .i_req_wr (i_req_wr), .i_req (i_req),
      .i_wr_data (i_wr_data), .i_lookup_tag (lookup_tag), .i_cpl_done (cpl_done),
      .o_bank_rd (bank_rd), .o_bank_wr (bank_wr), .o_reg_idx (reg_idx),
      .o_tag (tag), .o_wr_data (wr_data), .o_lookup_req (lookup_req), .o_busy (o_busy)
   );

   // --------------------------------------------------
   // CSR banks
   // --------------------------------------------------
   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      csr_bank bank_i (
         .clk (clk), .rst_n (rst_n),
         .i_rd (bank_rd[b]), .i_wr (bank_wr[b]), .i_reg_idx (reg_idx),
         .i_tag (tag), .i_wr_data (wr_data), .i_rsp_ready (bank_rsp_ready[b]),
         .o_rsp_valid (bank_rsp_valid[b]), .o_rsp (bank_rsp[b])
      );
   end : g_bank

   rsp_arbiter arb_i (
      .clk (clk), .rst_n (rst_n),
      .i_rsp_valid (bank_rsp_valid), .i_rsp (bank_rsp), .i_ready (arb_ready),
      .o_rsp_ready (bank_rsp_ready), .o_rsp_valid (arb_valid), .o_rsp (arb_rsp)
   );

   cpl_builder builder_i (
      .clk (clk), .rst_n (rst_n),
      .i_rsp_valid (arb_valid), .i_rsp (arb_rsp), .i_lookup_req (lookup_req),
      .i_cpl_ready (i_cpl_ready), .o_rsp_ready (arb_ready), .o_lookup_tag (lookup_tag),
      .o_cpl (o_cpl), .o_cpl_valid (o_cpl_valid), .o_cpl_done (cpl_done)
   );

endmodule : mmio_cpl_bridge

`default_nettype wire

// File: verif/mmio_cpl_checker.sv
// Protocol checker for the MMIO completion bridge ports
`timescale 1ns/10ps
`default_nettype none

module mmio_cpl_checker (
   input wire                 clk,
   input wire                 rst_n,
   input wire                 i_req_rd,
   input wire                 i_cpl_ready,
   input wire                 o_busy,
   input wire                 o_cpl_valid,
   input mmio_cpl_pkg::t_cpl  o_cpl
);

   // Record frozen while the sink stalls
   a_cpl_hold : assert property (@(posedge clk) disable iff (!rst_n)
      (o_cpl_valid && !i_cpl_ready) |=> (o_cpl_valid && $stable(o_cpl)))
      else $error("completion record changed while stalled");

   // Requester honors the throttle
   a_rd_not_busy : assert property (@(posedge clk) disable iff (!rst_n)
      i_req_rd |-> !o_busy)
      else $error("read strobe while busy");

   // Output empty out of reset
   a_rst_idle : assert property (@(posedge clk) !rst_n |=> !o_cpl_valid)
      else $error("completion valid right after reset");

endmodule : mmio_cpl_checker

bind mmio_cpl_bridge mmio_cpl_checker checker_i (
   .clk (clk), .rst_n (rst_n), .i_req_rd (i_req_rd), .i_cpl_ready (i_cpl_ready),
   .o_busy (o_busy), .o_cpl_valid (o_cpl_valid), .o_cpl (o_cpl)
);

`default_nettype wire

// File: verif/tb_mmio_cpl.sv
// Testbench for the MMIO completion bridge with register and completion models
`timescale 1ns/10ps
`default_nettype none

module tb_mmio_cpl;
   import mmio_cpl_pkg::*;

   // --------------------------------------------------
   // Run length
   // --------------------------------------------------
   localparam int NUM_OPS        = 48 + 12 + 40 + 4 + 32;
   localparam int CYCLES_PER_OP  = 200;
   localparam logic [31:0] LFSR_MASK = 32'hb4bc_d35c;

   logic       clk;
   logic       rst_n       = 1'b0;
   logic       i_req_rd    = 1'b0;
   logic       i_req_wr    = 1'b0;
   t_mmio_req  i_req       = '0;
   t_data      i_wr_data   = '0;
   logic       i_cpl_ready = 1'b1;
   logic       o_busy;
   t_cpl       o_cpl;
   logic       o_cpl_valid;

   logic [31:0] lfsr_state   = 32'hc2f8_829f;
   logic        stall_en     = 1'b0;
   logic        ready_next   = 1'b1;
   logic        verdict_done = 1'b0;
   t_tag        next_tag     = '0;
   int          n_pending    = 0;
   string       test_name    = "reset";
   t_data       model_regs [NUM_BANKS][NUM_IMPL_REGS];
   t_cpl        exp_cpl    [NUM_TAGS];
   logic        exp_pend   [NUM_TAGS];

   mmio_cpl_bridge dut_i (
      .clk (clk), .rst_n (rst_n), .i_req_rd (i_req_rd), .i_req_wr (i_req_wr),
      .i_req (i_req), .i_wr_data (i_wr_data), .i_cpl_ready (i_cpl_ready),
      .o_busy (o_busy), .o_cpl (o_cpl), .o_cpl_valid (o_cpl_valid)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // --------------------------------------------------
   // Helpers
   // --------------------------------------------------
   // Galois LFSR stepped once per bit
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] val;
      logic        lsb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lsb        = lfsr_state[0];
         lfsr_state = (lfsr_state >> 1) ^ (lsb ? LFSR_MASK : 32'h0);
         val        = {val[62:0], lsb};
      end
      return val;
   endfunction

   task automatic fail_now();
      verdict_done = 1'b1;
      $display("Something failed");
      $fatal(1, "stopped at first error");
   endtask

   // Header with random id, attr, tc and ignored address bits
   function automatic t_mmio_req make_req(input t_bank_idx bank, input t_reg_idx ridx,
                                          input logic dw, input logic [1:0] len);
      t_mmio_req  req;
      logic [3:0] addr_hi;
      logic [1:0] addr_lo;
      req.tag    = next_tag;
      req.req_id = t_req_id'(rand_bits(16));
      addr_hi    = 4'(rand_bits(4));
      addr_lo    = 2'(rand_bits(2));
      req.addr   = {addr_hi, bank, ridx, dw, addr_lo};
      req.length = len;
      req.attr   = 3'(rand_bits(3));
      req.tc     = 3'(rand_bits(3));
      next_tag   = t_tag'(next_tag + 1'b1);
      return req;
   endfunction

   // Completion predicted from the header and the register model
   function automatic t_cpl expect_cpl(input t_mmio_req req);
      t_cpl      want;
      t_bank_idx bank;
      t_reg_idx  ridx;
      bank            = req.addr[7:6];
      ridx            = req.addr[5:3];
      want            = '0;
      want.tag        = req.tag;
      want.req_id     = req.req_id;
      want.lower_addr = req.addr[6:0];
      want.length     = req.length;
      want.byte_count = 12'(req.length) * 12'd4;
      want.attr       = req.attr;
      want.tc         = req.tc;
      if (ridx >= t_reg_idx'(NUM_IMPL_REGS)) begin
         want.status = CPL_UR;
      end else begin
         want.status = CPL_SC;
         want.data   = model_regs[bank][ridx];
         // Upper dword moves down for a single-dword read
         if (req.length == 2'd1 && req.addr[2]) want.data = {32'h0, want.data[63:32]};
      end
      return want;
   endfunction

   task automatic issue_write(input t_bank_idx bank, input t_reg_idx ridx,
                              input t_data data);
      t_mmio_req req;
      req = make_req(bank, ridx, 1'b0, 2'd2);
      if (ridx < t_reg_idx'(NUM_IMPL_REGS)) model_regs[bank][ridx] = data;
      @(posedge clk);
      i_req_wr  <= 1'b1;
      i_req     <= req;
      i_wr_data <= data;
      @(posedge clk);
      i_req_wr  <= 1'b0;
   endtask

   task automatic issue_read(input t_bank_idx bank, input t_reg_idx ridx,
                             input logic dw, input logic [1:0] len);
      t_mmio_req req;
      req = make_req(bank, ridx, dw, len);
      // Hold off while the bridge is full
      @(negedge clk);
      while (o_busy) @(negedge clk);
      assert (!exp_pend[req.tag]) else begin
         $display("Tag %0d reused before its completion in %s", req.tag, test_name);
         fail_now();
      end
      exp_cpl[req.tag]  = expect_cpl(req);
      exp_pend[req.tag] = 1'b1;
      n_pending++;
      @(posedge clk);
      i_req_rd <= 1'b1;
      i_req    <= req;
      @(posedge clk);
      i_req_rd <= 1'b0;
   endtask

   task automatic wait_drain();
      while (n_pending != 0) @(posedge clk);
   endtask

   // Match a transferred record by tag
   task automatic check_cpl(input t_cpl got);
      t_cpl want;
      t_cpl seen;
      assert (exp_pend[got.tag]) else begin
         $display("Completion for tag %0d that is not outstanding in %s", got.tag, test_name);
         fail_now();
      end
      want = exp_cpl[got.tag];
      seen = got;
      // Error completions carry no data
      if (want.status == CPL_UR) seen.data = '0;
      assert (seen == want) else begin
         $display("[FAIL] %s: expected %h actual %h", test_name, want, seen);
         fail_now();
      end
      exp_pend[got.tag] = 1'b0;
      n_pending--;
   endtask

   // --------------------------------------------------
   // Output side
   // --------------------------------------------------
   // Transfers sampled mid-cycle where both levels are settled
   always @(negedge clk) begin
      if (rst_n && o_cpl_valid && i_cpl_ready) check_cpl(o_cpl);
   end

   // Stall pattern drawn mid-cycle away from the stimulus draws
   always @(negedge clk) begin
      ready_next = stall_en ? (rand_bits(1) != 64'd0) : 1'b1;
   end

   always @(posedge clk) begin
      i_cpl_ready <= ready_next;
   end

   // --------------------------------------------------
   // Directed tests
   // --------------------------------------------------
   task automatic write_read_all();
      test_name = "write_read_2dw";
      for (int b = 0; b < NUM_BANKS; b++) begin
         for (int r = 0; r < NUM_IMPL_REGS; r++) begin
            issue_write(t_bank_idx'(b), t_reg_idx'(r), rand_bits(64));
            issue_read(t_bank_idx'(b), t_reg_idx'(r), 1'(rand_bits(1)), 2'd2);
         end
      end
      wait_drain();
   endtask

   task automatic dword_reads();
      t_reg_idx ridx;
      test_name = "dword_reads";
      for (int b = 0; b < NUM_BANKS; b++) begin
         ridx = t_reg_idx'(rand_bits(3) % 64'd6);
         issue_write(t_bank_idx'(b), ridx, rand_bits(64));
         issue_read(t_bank_idx'(b), ridx, 1'b0, 2'd1);
         issue_read(t_bank_idx'(b), ridx, 1'b1, 2'd1);
      end
      wait_drain();
   endtask

   task automatic unimpl_regs();
      test_name = "unimpl_regs";
      for (int b = 0; b < NUM_BANKS; b++) begin
         issue_write(t_bank_idx'(b), 3'd6, rand_bits(64));
         issue_write(t_bank_idx'(b), 3'd7, rand_bits(64));
         issue_read(t_bank_idx'(b), 3'd6, 1'b0, 2'd2);
         issue_read(t_bank_idx'(b), 3'd7, 1'b1, 2'd1);
         for (int r = 0; r < NUM_IMPL_REGS; r++) begin
            issue_read(t_bank_idx'(b), t_reg_idx'(r), 1'b0, 2'd2);
         end
      end
      wait_drain();
   endtask

   task automatic cross_bank_reads();
      test_name = "cross_bank";
      issue_write(2'd1, 3'd2, rand_bits(64));
      issue_write(2'd3, 3'd4, rand_bits(64));
      issue_read(2'd3, 3'd4, 1'b0, 2'd2);
      issue_read(2'd1, 3'd2, 1'b0, 2'd2);
      @(negedge clk);
      assert (o_busy) else begin
         $display("[FAIL] %s: expected o_busy 1 actual %0b", test_name, o_busy);
         fail_now();
      end
      // One completion frees a slot
      while (n_pending == 2) @(posedge clk);
      @(negedge clk);
      assert (!o_busy) else begin
         $display("[FAIL] %s: expected o_busy 0 actual %0b", test_name, o_busy);
         fail_now();
      end
      wait_drain();
   endtask

   task automatic stalled_output();
      t_bank_idx  bank;
      t_reg_idx   ridx;
      logic       dw;
      logic [1:0] len;
      test_name = "back_pressure";
      stall_en  <= 1'b1;
      for (int i = 0; i < 24; i++) begin
         bank = t_bank_idx'(rand_bits(2));
         ridx = t_reg_idx'(rand_bits(3) % 64'd6);
         if (i % 3 == 0) issue_write(bank, ridx, rand_bits(64));
         dw  = 1'(rand_bits(1));
         len = (rand_bits(1) != 64'd0) ? 2'd2 : 2'd1;
         issue_read(bank, ridx, dw, len);
      end
      wait_drain();
      stall_en <= 1'b0;
   endtask

   // --------------------------------------------------
   // Sequence and limits
   // --------------------------------------------------
   initial begin : main
      for (int b = 0; b < NUM_BANKS; b++) begin
         for (int r = 0; r < NUM_IMPL_REGS; r++) model_regs[b][r] = '0;
      end
      for (int t = 0; t < NUM_TAGS; t++) exp_pend[t] = 1'b0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      write_read_all();
      dword_reads();
      unimpl_regs();
      cross_bank_reads();
      stalled_output();
      verdict_done = 1'b1;
      $display("Everything OK");
      $finish;
   end : main

   initial begin : watchdog
      repeat (NUM_OPS * CYCLES_PER_OP) @(posedge clk);
      $display("Timeout after %0d cycles in %s", NUM_OPS * CYCLES_PER_OP, test_name);
      fail_now();
   end : watchdog

   // Run stopped by a bound assertion
   final begin
      if (!verdict_done) $display("Something failed");
   end

endmodule : tb_mmio_cpl

`default_nettype wire

// File: mmio_cpl.f
src/mmio_cpl_pkg.sv
src/mmio_req_dispatch.sv
src/csr_bank.sv
src/rsp_arbiter.sv
src/cpl_builder.sv
src/mmio_cpl_bridge.sv
verif/mmio_cpl_checker.sv
verif/tb_mmio_cpl.sv

// File: Makefile
# Verilator build and run of the MMIO completion bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_mmio_cpl
FILELIST  ?= mmio_cpl.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Everything OK

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
